// File: common/spu_pkg.sv
package spu_pkg;

    // datapath geometry
    localparam int DATA_BITS  = 8;      // operand and result width
    localparam int OP_LATENCY = 2;      // enabled edges from input to output

    typedef logic [DATA_BITS-1:0] data_t;

    localparam data_t CLEAR_DATA = '0;  // value forced by s_clear and reset

    // one opcode per operation handled by the units
    typedef enum logic [2:0] {
        OP_AND  = 3'd0,
        OP_OR   = 3'd1,
        OP_XOR  = 3'd2,
        OP_XNOR = 3'd3,
        OP_ADD  = 3'd4,
        OP_SUB  = 3'd5
    } op_t;

    // selector tracking word holds the opcode plus one spare flag bit
    localparam int SEL_BITS = $bits(op_t) + 1;

endpackage

// File: common/spu_operand_if.sv
`timescale 1ns/1ps

interface spu_operand_if;

    spu_pkg::data_t data0;      // operand 0
    spu_pkg::data_t data1;      // operand 1
    spu_pkg::op_t   op;         // requested operation
    logic           clear;      // force stage data to clear value
    logic           valid;      // sample strobe

    // driven by the top level from its ports
    modport src (
        output data0,
        output data1,
        output op,
        output clear,
        output valid
    );

    // operators and selector only read
    modport unit (
        input  data0,
        input  data1,
        input  op,
        input  clear,
        input  valid
    );

endinterface

// File: design/spu_op_nop.sv
`timescale 1ns/1ps

module spu_op_nop #(
    parameter int LATENCY = spu_pkg::OP_LATENCY,   // number of delay stages
    parameter int WIDTH   = spu_pkg::DATA_BITS     // data width
) (
    input  logic             reset,     // synchronous, active high
    input  logic             clk,
    input  logic             cke,       // low freezes all stages

    input  logic [WIDTH-1:0] s_data,
    input  logic             s_clear,
    input  logic             s_valid,

    output logic [WIDTH-1:0] m_data,
    output logic             m_valid
);

    initial begin
        assert (LATENCY >= 0) else $error("spu_op_nop: negative LATENCY");
    end

    if (LATENCY == 0) begin : g_bypass
        assign m_data  = s_data;    // no stages at all
        assign m_valid = s_valid;
    end else begin : g_pipe
        logic [WIDTH-1:0] data_q  [LATENCY];
        logic             clear_q [LATENCY];
        logic             valid_q [LATENCY];
        logic [WIDTH-1:0] in_data [LATENCY];
        logic             in_clear[LATENCY];
        logic             in_valid[LATENCY];

        // stage i is fed by stage i-1, stage 0 by the inputs
        always_comb begin
            in_data[0]  = s_data;
            in_clear[0] = s_clear;
            in_valid[0] = s_valid;
            for (int i = 1; i < LATENCY; i++) begin
                in_data[i]  = data_q[i-1];
                in_clear[i] = clear_q[i-1];
                in_valid[i] = valid_q[i-1];
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                for (int i = 0; i < LATENCY; i++) begin
                    data_q[i]  <= WIDTH'(spu_pkg::CLEAR_DATA);
                    clear_q[i] <= 1'b0;
                    valid_q[i] <= 1'b0;
                end
            end else if (cke) begin
                for (int i = 0; i < LATENCY; i++) begin
                    if (in_clear[i]) begin
                        data_q[i] <= WIDTH'(spu_pkg::CLEAR_DATA);
                    end else if (in_valid[i]) begin
                        data_q[i] <= in_data[i];
                    end                                     // else hold
                    clear_q[i] <= in_clear[i];              // clear travels with sample
                    valid_q[i] <= in_valid[i];
                end
            end
        end

        assign m_data  = data_q[LATENCY-1];
        assign m_valid = valid_q[LATENCY-1];
    end

endmodule

// File: design/spu_op_xnor.sv
`timescale 1ns/1ps

module spu_op_xnor (
    input  logic                reset,
    input  logic                clk,
    input  logic                cke,
    spu_operand_if.unit         opnd,
    output spu_pkg::data_t      m_data
);

    spu_pkg::data_t st0_data;

    assign st0_data = ~(opnd.data0 ^ opnd.data1);   // bitwise xnor

    spu_op_nop #(
        .LATENCY (spu_pkg::OP_LATENCY),
        .WIDTH   (spu_pkg::DATA_BITS)
    ) u_latency (
        .reset   (reset),
        .clk     (clk),
        .cke     (cke),
        .s_data  (st0_data),
        .s_clear (opnd.clear),
        .s_valid (opnd.valid),
        .m_data  (m_data),
        .m_valid ()                 // valid tracked by the selector
    );

endmodule

// File: design/spu_op_logic.sv
`timescale 1ns/1ps

module spu_op_logic (
    input  logic                reset,
    input  logic                clk,
    input  logic                cke,
    spu_operand_if.unit         opnd,
    output spu_pkg::data_t      m_data
);

    spu_pkg::data_t st0_data;

    always_comb begin
        case (opnd.op)
            spu_pkg::OP_AND: st0_data = opnd.data0 & opnd.data1;
            spu_pkg::OP_OR:  st0_data = opnd.data0 | opnd.data1;
            // xor also covers opcodes this unit never serves
            default:         st0_data = opnd.data0 ^ opnd.data1;
        endcase
    end

    spu_op_nop #(
        .LATENCY (spu_pkg::OP_LATENCY),
        .WIDTH   (spu_pkg::DATA_BITS)
    ) u_latency (
        .reset   (reset),
        .clk     (clk),
        .cke     (cke),
        .s_data  (st0_data),
        .s_clear (opnd.clear),
        .s_valid (opnd.valid),
        .m_data  (m_data),
        .m_valid ()                 // unused, see selector
    );

endmodule

// File: design/spu_op_arith.sv
`timescale 1ns/1ps

module spu_op_arith (
    input  logic                reset,
    input  logic                clk,
    input  logic                cke,
    spu_operand_if.unit         opnd,
    output spu_pkg::data_t      m_data
);

    spu_pkg::data_t sum;
    spu_pkg::data_t diff;
    spu_pkg::data_t st0_data;

    // both wrap modulo 256 with carry and borrow dropped
    assign sum  = opnd.data0 + opnd.data1;
    assign diff = opnd.data0 - opnd.data1;

    always_comb begin
        if (opnd.op == spu_pkg::OP_ADD) begin
            st0_data = sum;
        end else begin
            st0_data = diff;        // OP_SUB and anything else
        end
    end

    spu_op_nop #(
        .LATENCY (spu_pkg::OP_LATENCY),
        .WIDTH   (spu_pkg::DATA_BITS)
    ) u_latency (
        .reset   (reset),
        .clk     (clk),
        .cke     (cke),
        .s_data  (st0_data),
        .s_clear (opnd.clear),
        .s_valid (opnd.valid),
        .m_data  (m_data),
        .m_valid ()
    );

endmodule

// File: design/spu_result_sel.sv
`timescale 1ns/1ps

module spu_result_sel (
    input  logic                reset,
    input  logic                clk,
    input  logic                cke,
    spu_operand_if.unit         opnd,
    input  spu_pkg::data_t      xnor_data,
    input  spu_pkg::data_t      logic_data,
    input  spu_pkg::data_t      arith_data,
    output spu_pkg::data_t      m_data,
    output logic                m_valid
);

    logic [spu_pkg::SEL_BITS-1:0] sel_in;
    logic [spu_pkg::SEL_BITS-1:0] sel_dly;
    logic                         is_arith;
    logic                         arith_dly;
    spu_pkg::op_t                 op_dly;

    // spare bit carries a pre-decoded arith flag
    assign is_arith = (opnd.op == spu_pkg::OP_ADD) || (opnd.op == spu_pkg::OP_SUB);
    assign sel_in   = {is_arith, opnd.op};

    // op follows the same hold rule as the data, so a held
    // sample keeps pointing at the unit it came from
    spu_op_nop #(
        .LATENCY (spu_pkg::OP_LATENCY),
        .WIDTH   (spu_pkg::SEL_BITS)
    ) u_op_dly (
        .reset   (reset),
        .clk     (clk),
        .cke     (cke),
        .s_data  (sel_in),
        .s_clear (1'b0),            // op never cleared
        .s_valid (opnd.valid),
        .m_data  (sel_dly),
        .m_valid (m_valid)
    );

    assign arith_dly = sel_dly[spu_pkg::SEL_BITS-1];
    assign op_dly    = spu_pkg::op_t'(sel_dly[spu_pkg::SEL_BITS-2:0]);

    always_comb begin
        if (arith_dly) begin
            m_data = arith_data;    // add / sub
        end else if (op_dly == spu_pkg::OP_XNOR) begin
            m_data = xnor_data;
        end else begin
            m_data = logic_data;    // and / or / xor
        end
    end

endmodule

// File: design/spu_top.sv
`timescale 1ns/1ps

module spu_top (
    input  logic            reset,      // synchronous, active high
    input  logic            clk,
    input  logic            cke,

    input  spu_pkg::op_t    op,
    input  spu_pkg::data_t  s_data0,
    input  spu_pkg::data_t  s_data1,
    input  logic            s_clear,
    input  logic            s_valid,

    output spu_pkg::data_t  m_data,
    output logic            m_valid
);

    spu_pkg::data_t xnor_data;
    spu_pkg::data_t logic_data;
    spu_pkg::data_t arith_data;

    spu_operand_if opnd ();

    // ports straight onto the operand bundle
    assign opnd.data0 = s_data0;
    assign opnd.data1 = s_data1;
    assign opnd.op    = op;
    assign opnd.clear = s_clear;
    assign opnd.valid = s_valid;

    // every unit runs each enabled cycle
    spu_op_xnor u_xnor (
        .reset  (reset),
        .clk    (clk),
        .cke    (cke),
        .opnd   (opnd.unit),
        .m_data (xnor_data)
    );

    spu_op_logic u_logic (
        .reset  (reset),
        .clk    (clk),
        .cke    (cke),
        .opnd   (opnd.unit),
        .m_data (logic_data)
    );

    spu_op_arith u_arith (
        .reset  (reset),
        .clk    (clk),
        .cke    (cke),
        .opnd   (opnd.unit),
        .m_data (arith_data)
    );

    spu_result_sel u_sel (
        .reset      (reset),
        .clk        (clk),
        .cke        (cke),
        .opnd       (opnd.unit),
        .xnor_data  (xnor_data),
        .logic_data (logic_data),
        .arith_data (arith_data),
        .m_data     (m_data),
        .m_valid    (m_valid)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 20          // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: testbench/spu_top_props.sv
`timescale 1ns/1ps

module spu_top_props (
    input logic           reset,
    input logic           clk,
    input logic           cke,
    input spu_pkg::op_t   op,
    input spu_pkg::data_t s_data0,
    input spu_pkg::data_t s_data1,
    input logic           s_clear,
    input logic           s_valid,
    input spu_pkg::data_t m_data,
    input logic           m_valid
);

    localparam int LAT  = spu_pkg::OP_LATENCY;
    localparam int TAIL = (LAT > 1) ? LAT - 2 : 0;

    int             fail_count = 0;     // read by the testbench top
    spu_pkg::data_t stg_res   [LAT];    // expected result per sample in flight
    logic           stg_clear [LAT];
    logic           stg_valid [LAT];
    spu_pkg::data_t exp_data;
    spu_pkg::data_t last_data;
    logic           last_valid;

    function automatic spu_pkg::data_t ref_result(input spu_pkg::op_t f_op,
                                                  input spu_pkg::data_t a,
                                                  input spu_pkg::data_t b);
        case (f_op)
            spu_pkg::OP_AND:  return a & b;
            spu_pkg::OP_OR:   return a | b;
            spu_pkg::OP_XOR:  return a ^ b;
            spu_pkg::OP_XNOR: return ~(a ^ b);
            spu_pkg::OP_ADD:  return a + b;     // wraps at 8 bits
            spu_pkg::OP_SUB:  return a - b;
            default:          return spu_pkg::CLEAR_DATA;
        endcase
    endfunction

    // sample about to reach the last stage
    wire            tail_clear = (LAT == 1) ? s_clear : stg_clear[TAIL];
    wire            tail_valid = (LAT == 1) ? s_valid : stg_valid[TAIL];
    spu_pkg::data_t tail_res;
    assign tail_res = (LAT == 1) ? ref_result(op, s_data0, s_data1) : stg_res[TAIL];

    always @(posedge clk) begin
        last_data  <= m_data;
        last_valid <= m_valid;
        if (reset) begin
            for (int i = 0; i < LAT; i++) begin
                stg_res[i]   <= spu_pkg::CLEAR_DATA;
                stg_clear[i] <= 1'b0;
                stg_valid[i] <= 1'b0;
            end
            exp_data <= spu_pkg::CLEAR_DATA;
        end else if (cke) begin
            stg_res[0]   <= ref_result(op, s_data0, s_data1);
            stg_clear[0] <= s_clear;
            stg_valid[0] <= s_valid;
            for (int i = 1; i < LAT; i++) begin
                stg_res[i]   <= stg_res[i-1];
                stg_clear[i] <= stg_clear[i-1];
                stg_valid[i] <= stg_valid[i-1];
            end
            if (tail_clear) begin
                exp_data <= spu_pkg::CLEAR_DATA;
            end else if (tail_valid) begin
                exp_data <= tail_res;
            end                             // neither clear nor valid holds
        end
    end

    a_data: assert property (@(posedge clk) disable iff (reset) m_data == exp_data)
        else begin
            fail_count++;
            $error("ERROR %0t m_data got %h expected %h", $time, $sampled(m_data),
                   $sampled(exp_data));
        end

    a_valid: assert property (@(posedge clk) disable iff (reset)
                              m_valid == stg_valid[LAT-1])
        else begin
            fail_count++;
            $error("ERROR %0t m_valid got %b expected %b", $time, $sampled(m_valid),
                   $sampled(stg_valid[LAT-1]));
        end

    // frozen pipeline
    a_cke_hold: assert property (@(posedge clk) disable iff (reset)
                                 !cke |=> m_data == last_data && m_valid == last_valid)
        else begin
            fail_count++;
            $error("ERROR %0t m_data got %h expected %h, m_valid got %b expected %b",
                   $time, $sampled(m_data), $sampled(last_data), $sampled(m_valid),
                   $sampled(last_valid));
        end

    a_reset: assert property (@(posedge clk) $fell(reset) |-> !m_valid && m_data == '0)
        else begin
            fail_count++;
            $error("ERROR %0t m_data got %h expected 00, m_valid got %b expected 0",
                   $time, $sampled(m_data), $sampled(m_valid));
        end

endmodule

bind spu_top spu_top_props u_props (
    .reset   (reset),
    .clk     (clk),
    .cke     (cke),
    .op      (op),
    .s_data0 (s_data0),
    .s_data1 (s_data1),
    .s_clear (s_clear),
    .s_valid (s_valid),
    .m_data  (m_data),
    .m_valid (m_valid)
);

// File: testbench/tb_spu_top.sv
`timescale 1ns/1ps

module tb_spu_top;

    logic           clk;
    logic           reset;
    logic           cke;
    spu_pkg::op_t   op;
    spu_pkg::data_t s_data0;
    spu_pkg::data_t s_data1;
    logic           s_clear;
    logic           s_valid;
    spu_pkg::data_t m_data;
    logic           m_valid;
    integer         seed;

    tb_clock #(.PERIOD(20)) u_clock (.clk(clk));

    spu_top spu_top_inst (
        .reset   (reset),
        .clk     (clk),
        .cke     (cke),
        .op      (op),
        .s_data0 (s_data0),
        .s_data1 (s_data1),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (m_data),
        .m_valid (m_valid)
    );

    task automatic abort_run(input string reason);
        $display("ERRORS FOUND");
        $fatal(1, "%s", reason);
    endtask

    // one sample per falling edge with random operands
    task automatic random_sample(input logic clr, input logic vld, input int op_idx);
        logic [31:0] r_word;
        @(negedge clk);
        r_word = $random(seed);
        s_data0 = r_word[spu_pkg::DATA_BITS-1:0];
        r_word = $random(seed);
        s_data1 = r_word[spu_pkg::DATA_BITS-1:0];
        r_word = $unsigned($random(seed)) % 6;
        if (op_idx >= 0) begin
            r_word = op_idx;
        end
        op      = spu_pkg::op_t'(r_word[2:0]);
        s_clear = clr;
        s_valid = vld;
    endtask

    task automatic wait_valid(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (m_valid !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (m_valid !== level) begin
            abort_run({"timeout waiting for m_valid during ", what});
        end
    endtask

    always @(negedge clk) begin
        if (spu_top_inst.u_props.fail_count != 0) begin
            abort_run("an assertion on spu_top failed");
        end
    end

    initial begin
        logic [31:0] r_word;
        seed    = 32'hb758eb85;
        reset   = 1'b1;
        cke     = 1'b1;
        op      = spu_pkg::OP_AND;
        s_data0 = '0;
        s_data1 = '0;
        s_clear = 1'b0;
        s_valid = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // every opcode once before the random results
        for (int i = 0; i < 6; i++) begin
            random_sample(1'b0, 1'b1, i);
        end
        for (int i = 0; i < 40; i++) begin
            r_word = $random(seed);
            random_sample(1'b0, r_word[1:0] != 2'b00, -1);
        end
        random_sample(1'b0, 1'b0, -1);
        wait_valid(1'b0, 8, "random drain");

        // clear with and without valid
        random_sample(1'b1, 1'b1, -1);
        random_sample(1'b1, 1'b0, -1);
        random_sample(1'b0, 1'b1, -1);
        random_sample(1'b1, 1'b1, -1);
        random_sample(1'b0, 1'b0, -1);
        wait_valid(1'b1, 8, "clear phase");
        wait_valid(1'b0, 8, "clear drain");

        // hold samples keep the last result
        random_sample(1'b0, 1'b1, -1);
        random_sample(1'b0, 1'b0, -1);
        wait_valid(1'b1, 8, "hold phase");
        for (int i = 0; i < 5; i++) begin
            random_sample(1'b0, 1'b0, -1);
        end
        wait_valid(1'b0, 8, "hold drain");

        // stall the pipeline while inputs keep changing
        for (int i = 0; i < 3; i++) begin
            random_sample(1'b0, 1'b1, -1);
        end
        cke = 1'b0;
        for (int i = 0; i < 6; i++) begin
            r_word = $random(seed);
            random_sample(r_word[0], 1'b1, -1);
        end
        cke = 1'b1;
        random_sample(1'b0, 1'b0, -1);
        wait_valid(1'b1, 8, "cke phase");
        wait_valid(1'b0, 8, "cke drain");

        @(negedge clk);
        if (spu_top_inst.u_props.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abort_run("an assertion on spu_top failed");
        end
    end

endmodule

// File: tb.f
common/spu_pkg.sv
common/spu_operand_if.sv
design/spu_op_nop.sv
design/spu_op_xnor.sv
design/spu_op_logic.sv
design/spu_op_arith.sv
design/spu_result_sel.sv
design/spu_top.sv
testbench/tb_clock.sv
testbench/spu_top_props.sv
testbench/tb_spu_top.sv

// File: run.sh
#!/bin/sh
# build and run the spu testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --no-stop-fail \
        -f tb.f --top-module tb_spu_top -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_spu_top; then
    echo "simulation failed"
    exit 1
fi

exit 0
